//--- run.sh
#!/bin/sh
# compile and run the msu audio testbench with verilator
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_msu_audio \
	-Mdir "$BUILD" -o tb_msu_audio
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD/tb_msu_audio" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0

//--- src.f
src/msu_pkg.sv
src/msu_sector_fetch.sv
src/msu_sample_fifo.sv
src/msu_sample_pacer.sv
src/msu_audio_mixer.sv
src/msu_audio_top.sv
verification/tb_msu_audio.sv

//--- src/msu_audio_mixer.sv
`timescale 1ns/1ps
//==================================================
// adds streamed audio onto the console stereo output
// sums clamp to -32768..32767, output registered once
//==================================================
module msu_audio_mixer (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 playing,
	input  msu_pkg::audio_pair_t main_audio,
	input  msu_pkg::audio_pair_t msu_audio,
	output msu_pkg::audio_pair_t audio_out
);
	msu_pkg::audio_pair_t gated;

	// signed add with clamp on overflow
	function automatic msu_pkg::sample_t sat_add(
		input msu_pkg::sample_t a,
		input msu_pkg::sample_t b
	);
		logic [msu_pkg::SAMPLE_W:0] sum;
		sum = {a[msu_pkg::SAMPLE_W-1], a} + {b[msu_pkg::SAMPLE_W-1], b};
		// top two bits differ on overflow
		if (sum[msu_pkg::SAMPLE_W] != sum[msu_pkg::SAMPLE_W-1])
			sat_add = sum[msu_pkg::SAMPLE_W] ? 16'sh8000 : 16'sh7fff;
		else
			sat_add = sum[msu_pkg::SAMPLE_W-1:0];
	endfunction

	// silence when stopped, no dc offset from stale samples
	assign gated = playing ? msu_audio : '0;

	//==================================================
	// output register
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			audio_out <= '0;
		end else begin
			audio_out.l <= sat_add(main_audio.l, gated.l);
			audio_out.r <= sat_add(main_audio.r, gated.r);
		end
	end

endmodule

//--- src/msu_audio_top.sv
`timescale 1ns/1ps
//==================================================
// msu audio streaming path, single clock domain
// parameters set here and passed to the sub blocks
//==================================================
module msu_audio_top #(
	parameter int FIFO_DEPTH_LOG2 = 12,
	parameter int REFILL_LEVEL    = 1176,
	parameter int LAST_SECTOR     = 2097151,
	parameter int SAMPLE_PERIOD   = 245
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 trig_play,
	input  logic                 track_mounting,
	input  msu_pkg::sd_xfer_t    sd_xfer,
	input  msu_pkg::audio_pair_t main_audio,
	output msu_pkg::sd_req_t     sd_req,
	output logic                 playing,
	output msu_pkg::audio_pair_t audio_out
);
	// fetch side to fifo
	logic [FIFO_DEPTH_LOG2:0] fill_level;
	logic                     fifo_full;
	logic                     fifo_wr;
	logic                     fifo_flush;
	// fifo to pacer
	logic                     fifo_empty;
	logic                     fifo_rd;
	msu_pkg::sample_t         fifo_data;
	msu_pkg::audio_pair_t     msu_audio;

	msu_sector_fetch #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
		.REFILL_LEVEL   (REFILL_LEVEL),
		.LAST_SECTOR    (LAST_SECTOR)
	) sector_fetch_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.trig_play      (trig_play),
		.track_mounting (track_mounting),
		.sd_xfer        (sd_xfer),
		.fill_level     (fill_level),
		.fifo_full      (fifo_full),
		.sd_req         (sd_req),
		.playing        (playing),
		.fifo_wr        (fifo_wr),
		.fifo_flush     (fifo_flush)
	);

	// host words go straight in
	msu_sample_fifo #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) sample_fifo_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.flush      (fifo_flush),
		.wr         (fifo_wr),
		.wr_data    (sd_xfer.data),
		.rd         (fifo_rd),
		.rd_data    (fifo_data),
		.full       (fifo_full),
		.empty      (fifo_empty),
		.fill_level (fill_level)
	);

	msu_sample_pacer #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD)
	) sample_pacer_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.trig_play      (trig_play),
		.playing        (playing),
		.track_mounting (track_mounting),
		.fifo_empty     (fifo_empty),
		.fifo_data      (fifo_data),
		.fifo_rd        (fifo_rd),
		.samples        (msu_audio)
	);

	msu_audio_mixer audio_mixer_inst (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.playing    (playing),
		.main_audio (main_audio),
		.msu_audio  (msu_audio),
		.audio_out  (audio_out)
	);

endmodule

//--- src/msu_pkg.sv
//==================================================
// shared types for the msu streamed audio path
// samples are signed 16 bit, one sector is 256 words
// lba width follows the host sector interface
//==================================================
package msu_pkg;

	//==================================================
	// widths and sector geometry
	//==================================================
	localparam int SAMPLE_W = 16;
	localparam int LBA_W    = 21;

	// 512 byte sector carried as 16 bit words
	localparam int SECTOR_WORDS = 256;

	//==================================================
	// audio types
	//==================================================
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef struct packed {
		sample_t l;
		sample_t r;
	} audio_pair_t;

	//==================================================
	// host sector interface
	//==================================================
	typedef logic [LBA_W-1:0] lba_t;

	// request side, rd is a level held until ack
	typedef struct packed {
		logic rd;
		lba_t lba;
	} sd_req_t;

	// ack stays high for the whole sector
	typedef struct packed {
		logic                ack;
		logic                buff_wr;
		logic [SAMPLE_W-1:0] data;
	} sd_xfer_t;

	// fetcher states
	typedef enum logic [1:0] {
		FETCH_IDLE     = 2'd0,
		FETCH_REQUEST  = 2'd1,
		FETCH_TRANSFER = 2'd2
	} fetch_state_t;

endpackage

//--- src/msu_sample_fifo.sv
`timescale 1ns/1ps
//==================================================
// single clock sample fifo, depth 2**FIFO_DEPTH_LOG2
// rd_data registered, valid the cycle after rd
// flush clears pointers, memory contents are left
//==================================================
module msu_sample_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 12
) (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     flush,
	input  logic                     wr,
	input  msu_pkg::sample_t         wr_data,
	input  logic                     rd,
	output msu_pkg::sample_t         rd_data,
	output logic                     full,
	output logic                     empty,
	output logic [FIFO_DEPTH_LOG2:0] fill_level
);
	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
	localparam logic [FIFO_DEPTH_LOG2:0] FULL_COUNT = {1'b1, {FIFO_DEPTH_LOG2{1'b0}}};

	msu_pkg::sample_t           mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2:0]   count;
	logic                       do_wr;
	logic                       do_rd;

	// overrun and underrun guarded here too
	assign do_wr      = wr && !full;
	assign do_rd      = rd && !empty;
	assign full       = count == FULL_COUNT;
	assign empty      = count == '0;
	assign fill_level = count;

	// storage and read port
	always_ff @(posedge clk_sys) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];
	end

	// pointers wrap naturally at the power of two depth
	always_ff @(posedge clk_sys) begin
		if (RESET || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// both sides must respect the flags
	a_no_rd_empty: assert property (@(posedge clk_sys) disable iff (RESET) rd |-> !empty);
	a_no_wr_full: assert property (@(posedge clk_sys) disable iff (RESET) wr |-> !full);

endmodule

//--- src/msu_sample_pacer.sv
`timescale 1ns/1ps
//==================================================
// one fifo read slot every SAMPLE_PERIOD clocks
// words alternate left then right, parity reset by trig_play
// samples hold their last value between updates
//==================================================
module msu_sample_pacer #(
	parameter int SAMPLE_PERIOD = 245
) (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 trig_play,
	input  logic                 playing,
	input  logic                 track_mounting,
	input  logic                 fifo_empty,
	input  msu_pkg::sample_t     fifo_data,
	output logic                 fifo_rd,
	output msu_pkg::audio_pair_t samples
);
	localparam int DIV_W = $clog2(SAMPLE_PERIOD + 1);
	localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(SAMPLE_PERIOD - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             slot;
	logic             rd_valid;
	logic             odd_word;

	//==================================================
	// slot divider
	//==================================================
	assign slot    = div_cnt == '0;
	// skip the slot if nothing buffered
	assign fifo_rd = slot && !fifo_empty && playing && !track_mounting;

	always_ff @(posedge clk_sys) begin
		if (RESET || slot)
			div_cnt <= DIV_LOAD;
		else
			div_cnt <= div_cnt - 1'b1;
	end

	//==================================================
	// channel steering
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rd_valid <= 1'b0;
			odd_word <= 1'b0;
			samples  <= '0;
		end else if (trig_play) begin
			// a read racing the flush is stale
			rd_valid <= 1'b0;
			odd_word <= 1'b0;
		end else begin
			rd_valid <= fifo_rd;
			if (rd_valid) begin
				// even word left, odd word right
				if (odd_word)
					samples.r <= fifo_data;
				else
					samples.l <= fifo_data;
				odd_word <= !odd_word;
			end
		end
	end

endmodule

//--- src/msu_sector_fetch.sv
`timescale 1ns/1ps
//==================================================
// sector fetcher, track starts at lba 0 and stops after LAST_SECTOR
// next sector only asked for once fill level <= REFILL_LEVEL
// playing stays set until RESET, trig_play restarts at lba 0
//==================================================
module msu_sector_fetch #(
	parameter int FIFO_DEPTH_LOG2 = 12,
	parameter int REFILL_LEVEL    = 1176,
	parameter int LAST_SECTOR     = 2097151
) (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     trig_play,
	input  logic                     track_mounting,
	input  msu_pkg::sd_xfer_t        sd_xfer,
	input  logic [FIFO_DEPTH_LOG2:0] fill_level,
	input  logic                     fifo_full,
	output msu_pkg::sd_req_t         sd_req,
	output logic                     playing,
	output logic                     fifo_wr,
	output logic                     fifo_flush
);
	localparam logic [FIFO_DEPTH_LOG2:0] REFILL_MARK = REFILL_LEVEL[FIFO_DEPTH_LOG2:0];
	localparam msu_pkg::lba_t LAST_LBA = LAST_SECTOR[msu_pkg::LBA_W-1:0];

	msu_pkg::fetch_state_t state;
	msu_pkg::lba_t         lba;
	logic                  req_rd;
	logic                  track_done;
	logic                  stream_ok;
	logic                  room_for_sector;

	// streaming allowed
	assign stream_ok       = playing && !track_mounting;
	assign room_for_sector = fill_level <= REFILL_MARK;

	// old track data is dropped on a new trigger
	assign fifo_flush = trig_play;
	// word strobe from the host, only while ack is up
	assign fifo_wr    = sd_xfer.ack && sd_xfer.buff_wr && stream_ok && !fifo_full;
	assign sd_req     = '{rd: req_rd, lba: lba};

	//==================================================
	// request fsm
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= msu_pkg::FETCH_IDLE;
			req_rd     <= 1'b0;
			lba        <= '0;
			playing    <= 1'b0;
			track_done <= 1'b0;
		end else if (trig_play) begin
			// restart from the first sector
			state      <= msu_pkg::FETCH_IDLE;
			req_rd     <= 1'b0;
			lba        <= '0;
			playing    <= 1'b1;
			track_done <= 1'b0;
		end else begin
			case (state)
				msu_pkg::FETCH_IDLE: begin
					if (stream_ok && !track_done) begin
						req_rd <= 1'b1;
						state  <= msu_pkg::FETCH_REQUEST;
					end
				end
				msu_pkg::FETCH_REQUEST: begin
					// host took the request
					if (sd_xfer.ack) begin
						req_rd <= 1'b0;
						state  <= msu_pkg::FETCH_TRANSFER;
					end
				end
				msu_pkg::FETCH_TRANSFER: begin
					// sector done, wait for space
					if (!sd_xfer.ack && room_for_sector) begin
						if (lba == LAST_LBA) begin
							state      <= msu_pkg::FETCH_IDLE;
							track_done <= 1'b1;
						end else if (!track_mounting) begin
							lba    <= lba + 1'b1;
							req_rd <= 1'b1;
							state  <= msu_pkg::FETCH_REQUEST;
						end
					end
				end
				default: state <= msu_pkg::FETCH_IDLE;
			endcase
		end
	end

	//==================================================
	// checks
	//==================================================
	// host must never see a request during the data phase
	a_no_rd_in_xfer: assert property (@(posedge clk_sys) disable iff (RESET)
		state == msu_pkg::FETCH_TRANSFER |-> !sd_req.rd);
	// a host word meeting a full fifo would be lost
	a_no_wr_full: assert property (@(posedge clk_sys) disable iff (RESET)
		sd_xfer.ack && sd_xfer.buff_wr && stream_ok |-> !fifo_full);
	// one full sector on top of the refill mark must fit
	a_refill_fits: assert property (@(posedge clk_sys)
		REFILL_LEVEL + msu_pkg::SECTOR_WORDS <= (1 << FIFO_DEPTH_LOG2));

endmodule

//--- verification/tb_msu_audio.sv
`timescale 1ns/1ps
//==================================================
// testbench for msu_audio_top, small fifo and short track
// host words count up from 0 across the sectors of a track
// checks run on the falling edge, all operands stable there
//==================================================
module tb_msu_audio;
	localparam int FIFO_DEPTH_LOG2 = 9;
	localparam int REFILL_LEVEL    = 128;
	localparam int LAST_SECTOR     = 5;
	localparam int SAMPLE_PERIOD   = 8;
	localparam int TRACK_WORDS     = (LAST_SECTOR + 1) * msu_pkg::SECTOR_WORDS;
	// full track, two sectors of the restart, then margin
	localparam int STREAM_CYCLES  = (LAST_SECTOR + 3) * msu_pkg::SECTOR_WORDS * SAMPLE_PERIOD;
	localparam int TIMEOUT_CYCLES = STREAM_CYCLES + STREAM_CYCLES / 4 + 2000;

	logic                 clk_sys;
	logic                 RESET;
	logic                 trig_play;
	logic                 track_mounting;
	msu_pkg::sd_xfer_t    sd_xfer;
	msu_pkg::audio_pair_t main_audio;
	msu_pkg::sd_req_t     sd_req;
	logic                 playing;
	msu_pkg::audio_pair_t audio_out;

	logic [31:0]          rng_state;
	int                   value_errors = 0;
	int                   other_errors = 0;
	int                   cycle_count = 0;
	int                   sat_cycles = 0;
	int                   word_count = 0;
	int                   sector;
	// reference model, updated on the rising edge
	logic                 rst_q = 1'b1;
	logic                 play_model;
	logic                 play_used;
	logic                 rd_q;
	logic [3:0]           mount_hist;
	msu_pkg::audio_pair_t main_q;
	int                   req_count;
	int                   last_l;
	int                   next_l;
	int                   last_r;
	int                   next_r;

	msu_audio_top #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
		.REFILL_LEVEL   (REFILL_LEVEL),
		.LAST_SECTOR    (LAST_SECTOR),
		.SAMPLE_PERIOD  (SAMPLE_PERIOD)
	) msu_audio_top_inst (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.trig_play      (trig_play),
		.track_mounting (track_mounting),
		.sd_xfer        (sd_xfer),
		.main_audio     (main_audio),
		.sd_req         (sd_req),
		.playing        (playing),
		.audio_out      (audio_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//==================================================
	// helpers
	//==================================================
	function automatic logic [31:0] rand_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// console sample plus gated stream sample, clamped
	function automatic int mix_expect(input int main_val, input int stream_val, input logic gate);
		int sum;
		sum = main_val + (gate ? stream_val : 0);
		if (sum > 32767)
			sum = 32767;
		else if (sum < -32768)
			sum = -32768;
		return sum;
	endfunction

	// true when the output shows the pending word and not the held one
	function automatic logic word_arrived(input int out_val, input int main_val,
			input int held, input int pending, input logic gate);
		int exp_new;
		int exp_held;
		exp_new  = mix_expect(main_val, pending, gate);
		exp_held = mix_expect(main_val, held, gate);
		return gate && out_val == exp_new && (exp_new != exp_held || pending == held);
	endfunction

	// one clock, main audio zero except during the clamp window
	task automatic tick();
		@(negedge clk_sys);
		if (sat_cycles > 0) begin
			main_audio.l = 16'sd32700;
			main_audio.r = -16'sd32760;
			sat_cycles--;
		end else begin
			main_audio = '0;
		end
	endtask

	task automatic trigger_play();
		tick();
		trig_play = 1'b1;
		tick();
		trig_play = 1'b0;
	endtask

	// host side of one sector, optional mount pause after it
	task automatic serve_sector(input bit pause_after);
		int wait_cycles;
		int gap;
		int i;
		while (!sd_req.rd)
			tick();
		wait_cycles = int'(rand_next() % 32'd4) + 1;
		repeat (wait_cycles) tick();
		sd_xfer.ack = 1'b1;
		for (i = 0; i < msu_pkg::SECTOR_WORDS; i++) begin
			gap = int'(rand_next() % 32'd3);
			repeat (gap) begin
				tick();
				sd_xfer.buff_wr = 1'b0;
			end
			tick();
			sd_xfer.buff_wr = 1'b1;
			sd_xfer.data    = 16'(word_count);
			word_count++;
		end
		tick();
		sd_xfer.buff_wr = 1'b0;
		if (pause_after) begin
			// host stays busy until the fifo is down to the refill mark
			while (word_count - (next_l + next_r - 1) / 2 > REFILL_LEVEL)
				tick();
		end
		sd_xfer = '0;
		if (pause_after) begin
			// same edge as ack low, fetcher has room but has to wait
			track_mounting = 1'b1;
			repeat (40) tick();
			track_mounting = 1'b0;
		end
	endtask

	//==================================================
	// reference model
	//==================================================
	always @(posedge clk_sys) begin
		rst_q       <= RESET;
		main_q      <= main_audio;
		play_used   <= play_model;
		rd_q        <= sd_req.rd;
		mount_hist  <= {mount_hist[2:0], track_mounting};
		cycle_count <= cycle_count + 1;
		if (RESET) begin
			play_model <= 1'b0;
			req_count  <= 0;
			last_l     <= 0;
			next_l     <= 0;
			last_r     <= 0;
			next_r     <= 1;
		end else if (trig_play) begin
			// held samples stay until the new words show up
			play_model <= 1'b1;
			req_count  <= 0;
			next_l     <= 0;
			next_r     <= 1;
		end else begin
			if (sd_req.rd && !rd_q)
				req_count <= req_count + 1;
			if (word_arrived(audio_out.l, main_q.l, last_l, next_l, play_used)) begin
				last_l <= next_l;
				next_l <= next_l + 2;
			end
			if (word_arrived(audio_out.r, main_q.r, last_r, next_r, play_used)) begin
				last_r <= next_r;
				next_r <= next_r + 2;
			end
		end
	end

	//==================================================
	// checks
	//==================================================
	a_playing: assert property (@(negedge clk_sys) disable iff (rst_q) playing == play_model)
		else begin
			value_errors++;
			$display("ERR %0t playing got %b exp %b", $time, playing, play_model);
		end
	a_idle_no_req: assert property (@(negedge clk_sys) disable iff (rst_q)
		!play_model |-> !sd_req.rd)
		else begin
			value_errors++;
			$display("ERR %0t sd_req.rd got %b exp 0", $time, sd_req.rd);
		end
	// even words on the left, in order
	a_left_word: assert property (@(negedge clk_sys) disable iff (rst_q)
		int'(audio_out.l) == mix_expect(main_q.l, last_l, play_used)
		|| int'(audio_out.l) == mix_expect(main_q.l, next_l, play_used))
		else begin
			value_errors++;
			$display("ERR %0t audio_out.l got %0d exp %0d or %0d", $time, audio_out.l,
				mix_expect(main_q.l, last_l, play_used), mix_expect(main_q.l, next_l, play_used));
		end
	a_right_word: assert property (@(negedge clk_sys) disable iff (rst_q)
		int'(audio_out.r) == mix_expect(main_q.r, last_r, play_used)
		|| int'(audio_out.r) == mix_expect(main_q.r, next_r, play_used))
		else begin
			value_errors++;
			$display("ERR %0t audio_out.r got %0d exp %0d or %0d", $time, audio_out.r,
				mix_expect(main_q.r, last_r, play_used), mix_expect(main_q.r, next_r, play_used));
		end
	// read pipeline is three deep, so four mounted edges means frozen
	a_mount_hold: assert property (@(negedge clk_sys) disable iff (rst_q)
		&mount_hist |-> int'(audio_out.l) == mix_expect(main_q.l, last_l, play_used)
		&& int'(audio_out.r) == mix_expect(main_q.r, last_r, play_used))
		else begin
			other_errors++;
			$display("%0t: audio output moved on while the track was mounting", $time);
		end
	a_req_lba: assert property (@(negedge clk_sys) disable iff (rst_q)
		(sd_req.rd && !rd_q) |-> int'(sd_req.lba) == req_count)
		else begin
			value_errors++;
			$display("ERR %0t sd_req.lba got %0d exp %0d", $time, sd_req.lba, req_count);
		end
	a_req_allowed: assert property (@(negedge clk_sys) disable iff (rst_q)
		(sd_req.rd && !rd_q) |-> req_count <= LAST_SECTOR && !mount_hist[0])
		else begin
			other_errors++;
			$display("%0t: sector request raised past the track end or while mounting", $time);
		end

	//==================================================
	// stimulus
	//==================================================
	initial begin : stimulus
		rng_state      = 32'habd9_5c47;
		RESET          = 1'b1;
		trig_play      = 1'b0;
		track_mounting = 1'b0;
		sd_xfer        = '0;
		main_audio     = '0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		// stopped, output follows the console audio
		repeat (60) begin
			@(negedge clk_sys);
			main_audio = rand_next();
		end
		trigger_play();
		for (sector = 0; sector <= LAST_SECTOR; sector++) begin
			if (sector == 3)
				sat_cycles = 10;
			serve_sector(sector == 2);
		end
		// last word of the track is odd, lands on the right
		while (next_r <= TRACK_WORDS)
			tick();
		repeat (200) tick();
		a_req_total: assert (req_count == LAST_SECTOR + 1)
			else begin
				value_errors++;
				$display("ERR %0t request count got %0d exp %0d", $time, req_count,
					LAST_SECTOR + 1);
			end
		// second play starts over at lba 0
		word_count = 0;
		trigger_play();
		for (sector = 0; sector < 2; sector++)
			serve_sector(1'b0);
		while (next_r <= 2 * msu_pkg::SECTOR_WORDS)
			tick();
		repeat (20) tick();
		$display("errors: value=%0d other=%0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin : watchdog
		wait (cycle_count >= TIMEOUT_CYCLES);
		other_errors++;
		$display("timeout after %0d cycles, fetch state %s", cycle_count,
			msu_audio_top_inst.sector_fetch_inst.state.name());
		$display("errors: value=%0d other=%0d", value_errors, other_errors);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
